//--- rtl/expand_pkg.sv
package expand_pkg;

  localparam int REG_W = 8;
  localparam int CNT_W = 3;
  localparam int DATA_W = 64;
  localparam int OPLEN_W = 2;
  localparam int BLEN_W = 6;
  localparam int WSLOT_W = 4;

  // Read slots one operation can fill.
  localparam int MAX_READS = 3;

  typedef logic [REG_W-1:0] reg_addr_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [OPLEN_W-1:0] oplen_t;
  typedef logic [BLEN_W-1:0] blen_t;
  typedef logic [WSLOT_W-1:0] wslot_t;

  // Read-port bank mask bits.
  localparam int BANK_VAU0_A = 0;
  localparam int BANK_VAU0_B = 1;
  localparam int BANK_VAU1_A = 2;
  localparam int BANK_VAU1_B = 3;
  localparam int BANK_VAU1_C = 4;
  localparam int BANK_VSDQ = 5;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_VIU,
    OP_VAU0,
    OP_VAU1,
    OP_VLDQ,
    OP_VSDQ
  } unit_op_e;

  typedef enum logic [1:0] {
    OPND_ZERO,
    OPND_REG,
    OPND_IMM
  } opnd_e;

  // Right source sits in the top bits, ALU op in the low nibble.
  typedef struct packed {
    opnd_e      right;
    opnd_e      left;
    logic [3:0] alu;
  } viu_fn_t;

  typedef logic [3:0] vau0_fn_t;
  typedef logic [3:0] vau1_fn_t;

  // Set for the three-operand fused form.
  localparam int VAU1_FMA_BIT = 2;

  typedef enum logic [2:0] {
    WSEL_VAU0 = 3'd0,
    WSEL_VAU1 = 3'd1,
    WSEL_VLDQ = 3'd3,
    WSEL_VIU  = 3'd4
  } wsel_e;

endpackage

//--- rtl/expand_decode.sv
module expand_decode
#(
  parameter int INT_STAGES = 1,
  parameter int IMUL_STAGES = 3,
  parameter int FMA_STAGES = 4
)
(
  input  logic                  seq_viu,
  input  logic                  seq_vau0,
  input  logic                  seq_vau1,
  input  logic                  seq_vldq,
  input  logic                  seq_vsdq,
  input  expand_pkg::viu_fn_t   seq_fn_viu,
  input  expand_pkg::vau0_fn_t  seq_fn_vau0,
  input  expand_pkg::vau1_fn_t  seq_fn_vau1,
  input  expand_pkg::reg_addr_t seq_vs,
  input  expand_pkg::reg_addr_t seq_vt,
  input  expand_pkg::reg_addr_t seq_vr,
  input  expand_pkg::reg_addr_t seq_vd,
  input  logic                  seq_vs_zero,
  input  logic                  seq_vt_zero,
  input  logic                  seq_vr_zero,
  input  expand_pkg::data_t     seq_imm,

  output logic                  rd_valid [expand_pkg::MAX_READS],
  output expand_pkg::reg_addr_t rd_addr [expand_pkg::MAX_READS],
  output expand_pkg::oplen_t    rd_oplen [expand_pkg::MAX_READS],
  output expand_pkg::blen_t     rd_blen [expand_pkg::MAX_READS],

  output expand_pkg::unit_op_e  fire_op,
  output logic [1:0]            fire_slot,
  output expand_pkg::viu_fn_t   viu_fn,
  output expand_pkg::vau0_fn_t  vau0_fn,
  output expand_pkg::vau1_fn_t  vau1_fn,
  output expand_pkg::data_t     imm,

  output logic                  wr_valid,
  output expand_pkg::wslot_t    wr_slot,
  output expand_pkg::reg_addr_t wr_addr,
  output expand_pkg::wsel_e     wr_sel
);

  expand_pkg::unit_op_e op;
  logic viu_rr;
  logic viu_zr;
  logic vau1_fma;

  always_comb
  begin
    if (seq_viu)
      op = expand_pkg::OP_VIU;
    else if (seq_vau0)
      op = expand_pkg::OP_VAU0;
    else if (seq_vau1)
      op = expand_pkg::OP_VAU1;
    else if (seq_vldq)
      op = expand_pkg::OP_VLDQ;
    else if (seq_vsdq)
      op = expand_pkg::OP_VSDQ;
    else
      op = expand_pkg::OP_NONE;
  end

  // The sequencer issues at most one operation per cycle.
  always_comb
  begin
    assert ($onehot0({seq_viu, seq_vau0, seq_vau1, seq_vldq, seq_vsdq}))
      else $error("expand_decode: more than one issue strobe");
  end

  assign viu_rr = seq_fn_viu.left == expand_pkg::OPND_REG
    && seq_fn_viu.right == expand_pkg::OPND_REG;
  assign viu_zr = seq_fn_viu.left == expand_pkg::OPND_ZERO
    && seq_fn_viu.right == expand_pkg::OPND_REG;
  assign vau1_fma = seq_fn_vau1[expand_pkg::VAU1_FMA_BIT];

  assign fire_op = op;
  assign vau0_fn = seq_fn_vau0;
  assign vau1_fn = seq_fn_vau1;
  assign wr_addr = seq_vd;

  always_comb
  begin
    for (int k = 0; k < expand_pkg::MAX_READS; k++)
    begin
      rd_valid[k] = 1'b0;
      rd_addr[k] = seq_vs;
      rd_oplen[k] = '0;
      rd_blen[k] = '0;
    end
    fire_slot = 2'd0;
    viu_fn = seq_fn_viu;
    imm = '0;
    wr_valid = 1'b0;
    wr_slot = '0;
    wr_sel = expand_pkg::WSEL_VIU;

    case (op)
      expand_pkg::OP_VIU:
      begin
        rd_valid[0] = 1'b1;
        rd_oplen[0] = 2'd1;
        wr_valid = 1'b1;
        if (viu_rr)
        begin
          rd_valid[1] = 1'b1;
          rd_addr[1] = seq_vt;
          fire_slot = 2'd1;
          wr_slot = expand_pkg::wslot_t'(INT_STAGES + 2);
          if (seq_vs_zero) viu_fn.left = expand_pkg::OPND_ZERO;
          if (seq_vt_zero) viu_fn.right = expand_pkg::OPND_ZERO;
        end
        else
        begin
          wr_slot = expand_pkg::wslot_t'(INT_STAGES + 1);
          imm = seq_imm;
          if (viu_zr)
            rd_addr[0] = seq_vt;
          else if (seq_vs_zero)
            viu_fn.left = expand_pkg::OPND_ZERO;
        end
      end
      expand_pkg::OP_VAU0:
      begin
        rd_valid[0] = 1'b1;
        rd_oplen[0] = 2'd1;
        rd_valid[1] = 1'b1;
        rd_addr[1] = seq_vt;
        rd_blen[1][expand_pkg::BANK_VAU0_A] = !seq_vs_zero;
        rd_blen[1][expand_pkg::BANK_VAU0_B] = !seq_vt_zero;
        fire_slot = 2'd1;
        wr_valid = 1'b1;
        wr_slot = expand_pkg::wslot_t'(IMUL_STAGES + 2);
        wr_sel = expand_pkg::WSEL_VAU0;
      end
      expand_pkg::OP_VAU1:
      begin
        rd_valid[0] = 1'b1;
        rd_oplen[0] = 2'd2;
        rd_valid[1] = 1'b1;
        rd_addr[1] = seq_vt;
        wr_valid = 1'b1;
        wr_sel = expand_pkg::WSEL_VAU1;
        if (vau1_fma)
        begin
          rd_oplen[1] = 2'd1;
          rd_valid[2] = 1'b1;
          rd_addr[2] = seq_vr;
          rd_blen[2][expand_pkg::BANK_VAU1_A] = !seq_vs_zero;
          rd_blen[2][expand_pkg::BANK_VAU1_B] = !seq_vt_zero;
          rd_blen[2][expand_pkg::BANK_VAU1_C] = !seq_vr_zero;
          fire_slot = 2'd2;
          wr_slot = expand_pkg::wslot_t'(FMA_STAGES + 3);
        end
        else
        begin
          // Two-operand form reads its second operand into the C port.
          rd_blen[1][expand_pkg::BANK_VAU1_A] = !seq_vs_zero;
          rd_blen[1][expand_pkg::BANK_VAU1_C] = !seq_vt_zero;
          fire_slot = 2'd1;
          wr_slot = expand_pkg::wslot_t'(FMA_STAGES + 2);
        end
      end
      expand_pkg::OP_VLDQ:
      begin
        wr_valid = 1'b1;
        wr_sel = expand_pkg::WSEL_VLDQ;
      end
      expand_pkg::OP_VSDQ:
      begin
        rd_valid[0] = 1'b1;
        rd_addr[0] = seq_vt;
        rd_blen[0][expand_pkg::BANK_VSDQ] = !seq_vt_zero;
      end
      default:
      begin
      end
    endcase
  end

endmodule

//--- rtl/read_schedule.sv
module read_schedule
#(
  parameter int READ_DEPTH = 3
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  last,
  input  expand_pkg::cnt_t      cnt,
  input  logic                  rd_valid [expand_pkg::MAX_READS],
  input  expand_pkg::reg_addr_t rd_addr [expand_pkg::MAX_READS],
  input  expand_pkg::oplen_t    rd_oplen [expand_pkg::MAX_READS],
  input  expand_pkg::blen_t     rd_blen [expand_pkg::MAX_READS],
  output logic                  ren,
  output logic                  rlast,
  output expand_pkg::cnt_t      rcnt,
  output expand_pkg::reg_addr_t raddr,
  output expand_pkg::oplen_t    roplen,
  output expand_pkg::blen_t     rblen
);

  typedef struct packed {
    logic                  last;
    expand_pkg::cnt_t      cnt;
    expand_pkg::reg_addr_t addr;
    expand_pkg::oplen_t    oplen;
    expand_pkg::blen_t     blen;
  } rd_entry_t;

  logic [READ_DEPTH-1:0] ren_q;
  logic [READ_DEPTH-1:0] ren_d;
  rd_entry_t entry_q [READ_DEPTH];
  rd_entry_t entry_d [READ_DEPTH];

  always_comb
  begin
    ren_d = ren_q >> 1;
    for (int i = 0; i < READ_DEPTH - 1; i++)
      entry_d[i] = entry_q[i + 1];
    entry_d[READ_DEPTH-1] = '0;
    // An operation fills its read slots starting at slot 0.
    for (int k = 0; k < expand_pkg::MAX_READS; k++)
    begin
      if (rd_valid[k])
      begin
        ren_d[k] = 1'b1;
        entry_d[k] = '{last, cnt, rd_addr[k], rd_oplen[k], rd_blen[k]};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      ren_q <= '0;
    else
      ren_q <= ren_d;
  end

  always_ff @(posedge clk)
  begin
    entry_q <= entry_d;
  end

  assign ren = ren_q[0];
  assign rlast = entry_q[0].last;
  assign rcnt = entry_q[0].cnt;
  assign raddr = entry_q[0].addr;
  assign roplen = entry_q[0].oplen;
  assign rblen = entry_q[0].blen;

  for (genvar k = 0; k + 1 < READ_DEPTH && k < expand_pkg::MAX_READS; k++)
  begin : g_collide
    assert property (@(posedge clk) disable iff (reset) !(rd_valid[k] && ren_q[k + 1]))
      else $error("read_schedule: slot %0d injected over a shifting entry", k);
  end

endmodule

//--- rtl/fire_schedule.sv
module fire_schedule
#(
  parameter int READ_DEPTH = 3
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  expand_pkg::unit_op_e fire_op,
  input  logic [1:0]           fire_slot,
  input  expand_pkg::viu_fn_t  viu_fn,
  input  expand_pkg::vau0_fn_t vau0_fn,
  input  expand_pkg::vau1_fn_t vau1_fn,
  input  expand_pkg::data_t    imm,
  output logic                 viu,
  output expand_pkg::viu_fn_t  viu_fn_out,
  output expand_pkg::data_t    viu_imm,
  output logic                 vau0,
  output expand_pkg::vau0_fn_t vau0_fn_out,
  output logic                 vau1,
  output expand_pkg::vau1_fn_t vau1_fn_out,
  output logic                 vldq,
  output logic                 vsdq
);

  typedef struct packed {
    expand_pkg::viu_fn_t  viu_fn;
    expand_pkg::vau0_fn_t vau0_fn;
    expand_pkg::vau1_fn_t vau1_fn;
  } fn_entry_t;

  expand_pkg::unit_op_e op_q [READ_DEPTH];
  expand_pkg::unit_op_e op_d [READ_DEPTH];
  fn_entry_t fn_q [READ_DEPTH];
  fn_entry_t fn_d [READ_DEPTH];
  expand_pkg::data_t imm_q;
  logic [READ_DEPTH-1:0] busy;
  logic [READ_DEPTH-1:0] ahead;

  always_comb
  begin
    for (int i = 0; i < READ_DEPTH; i++)
    begin
      busy[i] = op_q[i] != expand_pkg::OP_NONE;
      op_d[i] = (i < READ_DEPTH - 1) ? op_q[(i + 1) % READ_DEPTH] : expand_pkg::OP_NONE;
      fn_d[i] = fn_q[(i + 1) % READ_DEPTH];
      if (fire_op != expand_pkg::OP_NONE && fire_slot == i)
      begin
        op_d[i] = fire_op;
        fn_d[i] = '{viu_fn, vau0_fn, vau1_fn};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < READ_DEPTH; i++)
        op_q[i] <= expand_pkg::OP_NONE;
    end
    else
      op_q <= op_d;
  end

  // Decode only hands over an immediate for a slot-0 VIU fire.
  always_ff @(posedge clk)
  begin
    fn_q <= fn_d;
    imm_q <= imm;
  end

  assign viu = op_q[0] == expand_pkg::OP_VIU;
  assign vau0 = op_q[0] == expand_pkg::OP_VAU0;
  assign vau1 = op_q[0] == expand_pkg::OP_VAU1;
  assign vldq = op_q[0] == expand_pkg::OP_VLDQ;
  assign vsdq = op_q[0] == expand_pkg::OP_VSDQ;
  assign viu_fn_out = fn_q[0].viu_fn;
  assign vau0_fn_out = fn_q[0].vau0_fn;
  assign vau1_fn_out = fn_q[0].vau1_fn;
  assign viu_imm = imm_q;

  assign ahead = (busy >> 1) >> fire_slot;

  assert property (@(posedge clk) disable iff (reset)
    fire_op != expand_pkg::OP_NONE |-> !ahead[0])
    else $error("fire_schedule: fire slot %0d injected over a shifting fire", fire_slot);

endmodule

//--- rtl/write_schedule.sv
module write_schedule
#(
  parameter int WRITE_DEPTH = 12
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  last,
  input  expand_pkg::cnt_t      cnt,
  input  logic                  wr_valid,
  input  expand_pkg::wslot_t    wr_slot,
  input  expand_pkg::reg_addr_t wr_addr,
  input  expand_pkg::wsel_e     wr_sel,
  output logic                  wen,
  output logic                  wlast,
  output expand_pkg::cnt_t      wcnt,
  output expand_pkg::reg_addr_t waddr,
  output expand_pkg::wsel_e     wsel
);

  typedef struct packed {
    logic                  last;
    expand_pkg::cnt_t      cnt;
    expand_pkg::reg_addr_t addr;
    expand_pkg::wsel_e     sel;
  } wr_entry_t;

  logic [WRITE_DEPTH-1:0] wen_q;
  logic [WRITE_DEPTH-1:0] wen_d;
  logic [WRITE_DEPTH-1:0] ahead;
  wr_entry_t entry_q [WRITE_DEPTH];
  wr_entry_t entry_d [WRITE_DEPTH];

  always_comb
  begin
    wen_d = wen_q >> 1;
    for (int i = 0; i < WRITE_DEPTH; i++)
    begin
      entry_d[i] = entry_q[(i + 1) % WRITE_DEPTH];
      // Result latency decides which slot the writeback lands in.
      if (wr_valid && wr_slot == i)
      begin
        wen_d[i] = 1'b1;
        entry_d[i] = '{last, cnt, wr_addr, wr_sel};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      wen_q <= '0;
    else
      wen_q <= wen_d;
  end

  always_ff @(posedge clk)
  begin
    entry_q <= entry_d;
  end

  assign wen = wen_q[0];
  assign wlast = entry_q[0].last;
  assign wcnt = entry_q[0].cnt;
  assign waddr = entry_q[0].addr;
  assign wsel = entry_q[0].sel;

  assign ahead = (wen_q >> 1) >> wr_slot;

  assert property (@(posedge clk) disable iff (reset) wr_valid |-> wr_slot < WRITE_DEPTH)
    else $error("write_schedule: slot %0d beyond the buffer", wr_slot);

  assert property (@(posedge clk) disable iff (reset) wr_valid |-> !ahead[0])
    else $error("write_schedule: slot %0d injected over a shifting write", wr_slot);

endmodule

//--- rtl/vector_expand.sv
module vector_expand
#(
  parameter int READ_DEPTH = 3,
  parameter int WRITE_DEPTH = 12,
  parameter int INT_STAGES = 1,
  parameter int IMUL_STAGES = 3,
  parameter int FMA_STAGES = 4
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  seq_last,
  input  logic                  seq_viu,
  input  logic                  seq_vau0,
  input  logic                  seq_vau1,
  input  logic                  seq_vldq,
  input  logic                  seq_vsdq,
  input  expand_pkg::viu_fn_t   seq_fn_viu,
  input  expand_pkg::vau0_fn_t  seq_fn_vau0,
  input  expand_pkg::vau1_fn_t  seq_fn_vau1,
  input  expand_pkg::cnt_t      seq_cnt,
  input  logic                  seq_vs_zero,
  input  logic                  seq_vt_zero,
  input  logic                  seq_vr_zero,
  input  expand_pkg::reg_addr_t seq_vs,
  input  expand_pkg::reg_addr_t seq_vt,
  input  expand_pkg::reg_addr_t seq_vr,
  input  expand_pkg::reg_addr_t seq_vd,
  input  expand_pkg::data_t     seq_imm,

  output logic                  expand_ren,
  output logic                  expand_rlast,
  output expand_pkg::cnt_t      expand_rcnt,
  output expand_pkg::reg_addr_t expand_raddr,
  output expand_pkg::oplen_t    expand_roplen,
  output expand_pkg::blen_t     expand_rblen,
  output logic                  expand_wen,
  output logic                  expand_wlast,
  output expand_pkg::cnt_t      expand_wcnt,
  output expand_pkg::reg_addr_t expand_waddr,
  output expand_pkg::wsel_e     expand_wsel,
  output logic                  expand_viu,
  output expand_pkg::viu_fn_t   expand_viu_fn,
  output expand_pkg::data_t     expand_viu_imm,
  output logic                  expand_vau0,
  output expand_pkg::vau0_fn_t  expand_vau0_fn,
  output logic                  expand_vau1,
  output expand_pkg::vau1_fn_t  expand_vau1_fn,
  output logic                  expand_vldq,
  output logic                  expand_vsdq
);

  logic                  rd_valid [expand_pkg::MAX_READS];
  expand_pkg::reg_addr_t rd_addr [expand_pkg::MAX_READS];
  expand_pkg::oplen_t    rd_oplen [expand_pkg::MAX_READS];
  expand_pkg::blen_t     rd_blen [expand_pkg::MAX_READS];
  expand_pkg::unit_op_e  fire_op;
  logic [1:0]            fire_slot;
  expand_pkg::viu_fn_t   viu_fn;
  expand_pkg::vau0_fn_t  vau0_fn;
  expand_pkg::vau1_fn_t  vau1_fn;
  expand_pkg::data_t     imm;
  logic                  wr_valid;
  expand_pkg::wslot_t    wr_slot;
  expand_pkg::reg_addr_t wr_addr;
  expand_pkg::wsel_e     wr_sel;

  expand_decode #(
    .INT_STAGES(INT_STAGES),
    .IMUL_STAGES(IMUL_STAGES),
    .FMA_STAGES(FMA_STAGES)
  ) decode_i (
    .seq_viu(seq_viu), .seq_vau0(seq_vau0), .seq_vau1(seq_vau1),
    .seq_vldq(seq_vldq), .seq_vsdq(seq_vsdq),
    .seq_fn_viu(seq_fn_viu), .seq_fn_vau0(seq_fn_vau0), .seq_fn_vau1(seq_fn_vau1),
    .seq_vs(seq_vs), .seq_vt(seq_vt), .seq_vr(seq_vr), .seq_vd(seq_vd),
    .seq_vs_zero(seq_vs_zero), .seq_vt_zero(seq_vt_zero), .seq_vr_zero(seq_vr_zero),
    .seq_imm(seq_imm),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_oplen(rd_oplen), .rd_blen(rd_blen),
    .fire_op(fire_op), .fire_slot(fire_slot), .viu_fn(viu_fn),
    .vau0_fn(vau0_fn), .vau1_fn(vau1_fn), .imm(imm),
    .wr_valid(wr_valid), .wr_slot(wr_slot), .wr_addr(wr_addr), .wr_sel(wr_sel)
  );

  read_schedule #(.READ_DEPTH(READ_DEPTH)) read_i (
    .clk(clk), .reset(reset), .last(seq_last), .cnt(seq_cnt),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_oplen(rd_oplen), .rd_blen(rd_blen),
    .ren(expand_ren), .rlast(expand_rlast), .rcnt(expand_rcnt),
    .raddr(expand_raddr), .roplen(expand_roplen), .rblen(expand_rblen)
  );

  fire_schedule #(.READ_DEPTH(READ_DEPTH)) fire_i (
    .clk(clk), .reset(reset), .fire_op(fire_op), .fire_slot(fire_slot),
    .viu_fn(viu_fn), .vau0_fn(vau0_fn), .vau1_fn(vau1_fn), .imm(imm),
    .viu(expand_viu), .viu_fn_out(expand_viu_fn), .viu_imm(expand_viu_imm),
    .vau0(expand_vau0), .vau0_fn_out(expand_vau0_fn),
    .vau1(expand_vau1), .vau1_fn_out(expand_vau1_fn),
    .vldq(expand_vldq), .vsdq(expand_vsdq)
  );

  write_schedule #(.WRITE_DEPTH(WRITE_DEPTH)) write_i (
    .clk(clk), .reset(reset), .last(seq_last), .cnt(seq_cnt),
    .wr_valid(wr_valid), .wr_slot(wr_slot), .wr_addr(wr_addr), .wr_sel(wr_sel),
    .wen(expand_wen), .wlast(expand_wlast), .wcnt(expand_wcnt),
    .waddr(expand_waddr), .wsel(expand_wsel)
  );

endmodule

//--- test/tb_vector_expand.sv
module tb_vector_expand;

  localparam int WRITE_DEPTH = 12;
  localparam int INT_STAGES = 1;
  localparam int IMUL_STAGES = 3;
  localparam int FMA_STAGES = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_OPS = 76;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (WRITE_DEPTH + 4) + RESET_CYCLES;
  localparam int HIST = TIMEOUT_CYCLES + WRITE_DEPTH + 4;

  logic clk;
  logic reset;
  logic seq_last, seq_viu, seq_vau0, seq_vau1, seq_vldq, seq_vsdq;
  logic seq_vs_zero, seq_vt_zero, seq_vr_zero;
  expand_pkg::viu_fn_t seq_fn_viu;
  expand_pkg::vau0_fn_t seq_fn_vau0;
  expand_pkg::vau1_fn_t seq_fn_vau1;
  expand_pkg::cnt_t seq_cnt;
  expand_pkg::reg_addr_t seq_vs, seq_vt, seq_vr, seq_vd;
  expand_pkg::data_t seq_imm;

  logic expand_ren, expand_rlast, expand_wen, expand_wlast;
  logic expand_viu, expand_vau0, expand_vau1, expand_vldq, expand_vsdq;
  expand_pkg::cnt_t expand_rcnt, expand_wcnt;
  expand_pkg::reg_addr_t expand_raddr, expand_waddr;
  expand_pkg::oplen_t expand_roplen;
  expand_pkg::blen_t expand_rblen;
  expand_pkg::wsel_e expand_wsel;
  expand_pkg::viu_fn_t expand_viu_fn;
  expand_pkg::data_t expand_viu_imm;
  expand_pkg::vau0_fn_t expand_vau0_fn;
  expand_pkg::vau1_fn_t expand_vau1_fn;
  logic [4:0] fire_act;

  // Expected outputs, indexed by the cycle in which they must be visible.
  bit exp_ren [HIST];
  logic exp_rlast [HIST];
  expand_pkg::cnt_t exp_rcnt [HIST];
  expand_pkg::reg_addr_t exp_raddr [HIST];
  expand_pkg::oplen_t exp_roplen [HIST];
  expand_pkg::blen_t exp_rblen [HIST];
  expand_pkg::unit_op_e exp_fire [HIST];
  expand_pkg::viu_fn_t exp_viu_fn [HIST];
  expand_pkg::data_t exp_imm [HIST];
  expand_pkg::vau0_fn_t exp_vau0_fn [HIST];
  expand_pkg::vau1_fn_t exp_vau1_fn [HIST];
  bit exp_wen [HIST];
  logic exp_wlast [HIST];
  expand_pkg::cnt_t exp_wcnt [HIST];
  expand_pkg::reg_addr_t exp_waddr [HIST];
  expand_pkg::wsel_e exp_wsel [HIST];

  int cyc = 0;
  int seed = 16;
  int errors = 0;
  int mark = 0;
  int tests = 0;
  int ops = 0;

  vector_expand #(
    .READ_DEPTH(3),
    .WRITE_DEPTH(WRITE_DEPTH),
    .INT_STAGES(INT_STAGES),
    .IMUL_STAGES(IMUL_STAGES),
    .FMA_STAGES(FMA_STAGES)
  ) vector_expand_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  assign fire_act = {expand_viu, expand_vau0, expand_vau1, expand_vldq, expand_vsdq};

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    errors++;
    $display("FAIL %s: expected %h, got %h at cycle %0d", name, expected, actual, cyc);
  endtask

  function automatic logic [4:0] fire_vector(input expand_pkg::unit_op_e op);
    return {op == expand_pkg::OP_VIU, op == expand_pkg::OP_VAU0, op == expand_pkg::OP_VAU1,
            op == expand_pkg::OP_VLDQ, op == expand_pkg::OP_VSDQ};
  endfunction

  function automatic int random_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Outputs are stable at the falling edge.
  assert property (@(negedge clk) disable iff (reset) expand_ren == exp_ren[cyc])
    else report_mismatch("expand_ren", 64'(exp_ren[cyc]), 64'(expand_ren));
  assert property (@(negedge clk) disable iff (reset)
    exp_ren[cyc] |-> expand_raddr == exp_raddr[cyc])
    else report_mismatch("expand_raddr", 64'(exp_raddr[cyc]), 64'(expand_raddr));
  assert property (@(negedge clk) disable iff (reset)
    exp_ren[cyc] |-> expand_roplen == exp_roplen[cyc])
    else report_mismatch("expand_roplen", 64'(exp_roplen[cyc]), 64'(expand_roplen));
  assert property (@(negedge clk) disable iff (reset)
    exp_ren[cyc] |-> expand_rblen == exp_rblen[cyc])
    else report_mismatch("expand_rblen", 64'(exp_rblen[cyc]), 64'(expand_rblen));
  assert property (@(negedge clk) disable iff (reset)
    exp_ren[cyc] |-> expand_rlast == exp_rlast[cyc])
    else report_mismatch("expand_rlast", 64'(exp_rlast[cyc]), 64'(expand_rlast));
  assert property (@(negedge clk) disable iff (reset)
    exp_ren[cyc] |-> expand_rcnt == exp_rcnt[cyc])
    else report_mismatch("expand_rcnt", 64'(exp_rcnt[cyc]), 64'(expand_rcnt));
  assert property (@(negedge clk) disable iff (reset) expand_wen == exp_wen[cyc])
    else report_mismatch("expand_wen", 64'(exp_wen[cyc]), 64'(expand_wen));
  assert property (@(negedge clk) disable iff (reset)
    exp_wen[cyc] |-> expand_waddr == exp_waddr[cyc])
    else report_mismatch("expand_waddr", 64'(exp_waddr[cyc]), 64'(expand_waddr));
  assert property (@(negedge clk) disable iff (reset)
    exp_wen[cyc] |-> expand_wsel == exp_wsel[cyc])
    else report_mismatch("expand_wsel", 64'(exp_wsel[cyc]), 64'(expand_wsel));
  assert property (@(negedge clk) disable iff (reset)
    exp_wen[cyc] |-> expand_wlast == exp_wlast[cyc])
    else report_mismatch("expand_wlast", 64'(exp_wlast[cyc]), 64'(expand_wlast));
  assert property (@(negedge clk) disable iff (reset)
    exp_wen[cyc] |-> expand_wcnt == exp_wcnt[cyc])
    else report_mismatch("expand_wcnt", 64'(exp_wcnt[cyc]), 64'(expand_wcnt));
  assert property (@(negedge clk) disable iff (reset) fire_act == fire_vector(exp_fire[cyc]))
    else report_mismatch("expand_viu/vau0/vau1/vldq/vsdq",
                         64'(fire_vector(exp_fire[cyc])), 64'(fire_act));
  assert property (@(negedge clk) disable iff (reset)
    exp_fire[cyc] == expand_pkg::OP_VIU |-> expand_viu_fn == exp_viu_fn[cyc])
    else report_mismatch("expand_viu_fn", 64'(exp_viu_fn[cyc]), 64'(expand_viu_fn));
  assert property (@(negedge clk) disable iff (reset)
    exp_fire[cyc] == expand_pkg::OP_VIU |-> expand_viu_imm == exp_imm[cyc])
    else report_mismatch("expand_viu_imm", exp_imm[cyc], expand_viu_imm);
  assert property (@(negedge clk) disable iff (reset)
    exp_fire[cyc] == expand_pkg::OP_VAU0 |-> expand_vau0_fn == exp_vau0_fn[cyc])
    else report_mismatch("expand_vau0_fn", 64'(exp_vau0_fn[cyc]), 64'(expand_vau0_fn));
  assert property (@(negedge clk) disable iff (reset)
    exp_fire[cyc] == expand_pkg::OP_VAU1 |-> expand_vau1_fn == exp_vau1_fn[cyc])
    else report_mismatch("expand_vau1_fn", 64'(exp_vau1_fn[cyc]), 64'(expand_vau1_fn));

  task automatic randomize_fields();
    seq_vs = expand_pkg::reg_addr_t'(random_below(256));
    seq_vt = expand_pkg::reg_addr_t'(random_below(256));
    seq_vr = expand_pkg::reg_addr_t'(random_below(256));
    seq_vd = expand_pkg::reg_addr_t'(random_below(256));
    seq_last = random_below(2) == 1;
    seq_cnt = expand_pkg::cnt_t'(random_below(8));
    seq_vs_zero = random_below(2) == 1;
    seq_vt_zero = random_below(2) == 1;
    seq_vr_zero = random_below(2) == 1;
    seq_imm = {32'($random(seed)), 32'($random(seed))};
    seq_fn_viu.alu = 4'(random_below(16));
    seq_fn_viu.left = expand_pkg::opnd_e'(random_below(3));
    seq_fn_viu.right = expand_pkg::opnd_e'(random_below(3));
    seq_fn_vau0 = expand_pkg::vau0_fn_t'(random_below(16));
    seq_fn_vau1 = expand_pkg::vau1_fn_t'(random_below(16));
  endtask

  // Reference model of the slot rules; waits until the target slots are free.
  task automatic issue(input expand_pkg::unit_op_e unit);
    int nrd;
    int fslot;
    int wslot;
    int base;
    bit busy;
    expand_pkg::reg_addr_t ra [3];
    expand_pkg::oplen_t ro [3];
    expand_pkg::blen_t rb [3];
    expand_pkg::viu_fn_t fn;
    expand_pkg::data_t imm_exp;
    expand_pkg::wsel_e sel;
    nrd = 0;
    fslot = 0;
    wslot = -1;
    fn = seq_fn_viu;
    imm_exp = '0;
    sel = expand_pkg::WSEL_VIU;
    ra[0] = seq_vs;
    ra[1] = seq_vt;
    ra[2] = seq_vr;
    for (int k = 0; k < 3; k++)
    begin
      ro[k] = 2'd0;
      rb[k] = '0;
    end
    case (unit)
      expand_pkg::OP_VIU:
      begin
        ro[0] = 2'd1;
        if (seq_vs_zero)
          fn.left = expand_pkg::OPND_ZERO;
        if (seq_fn_viu.left == expand_pkg::OPND_REG && seq_fn_viu.right == expand_pkg::OPND_REG)
        begin
          nrd = 2;
          fslot = 1;
          wslot = INT_STAGES + 2;
          if (seq_vt_zero)
            fn.right = expand_pkg::OPND_ZERO;
        end
        else
        begin
          nrd = 1;
          wslot = INT_STAGES + 1;
          imm_exp = seq_imm;
          if (seq_fn_viu.left == expand_pkg::OPND_ZERO && seq_fn_viu.right == expand_pkg::OPND_REG)
            ra[0] = seq_vt;
        end
      end
      expand_pkg::OP_VAU0:
      begin
        nrd = 2;
        ro[0] = 2'd1;
        rb[1][expand_pkg::BANK_VAU0_A] = !seq_vs_zero;
        rb[1][expand_pkg::BANK_VAU0_B] = !seq_vt_zero;
        fslot = 1;
        wslot = IMUL_STAGES + 2;
        sel = expand_pkg::WSEL_VAU0;
      end
      expand_pkg::OP_VAU1:
      begin
        ro[0] = 2'd2;
        sel = expand_pkg::WSEL_VAU1;
        if (seq_fn_vau1[expand_pkg::VAU1_FMA_BIT])
        begin
          nrd = 3;
          ro[1] = 2'd1;
          rb[2][expand_pkg::BANK_VAU1_A] = !seq_vs_zero;
          rb[2][expand_pkg::BANK_VAU1_B] = !seq_vt_zero;
          rb[2][expand_pkg::BANK_VAU1_C] = !seq_vr_zero;
          fslot = 2;
          wslot = FMA_STAGES + 3;
        end
        else
        begin
          nrd = 2;
          rb[1][expand_pkg::BANK_VAU1_A] = !seq_vs_zero;
          rb[1][expand_pkg::BANK_VAU1_C] = !seq_vt_zero;
          fslot = 1;
          wslot = FMA_STAGES + 2;
        end
      end
      expand_pkg::OP_VLDQ:
      begin
        wslot = 0;
        sel = expand_pkg::WSEL_VLDQ;
      end
      default:
      begin
        nrd = 1;
        ra[0] = seq_vt;
        rb[0][expand_pkg::BANK_VSDQ] = !seq_vt_zero;
      end
    endcase

    busy = 1'b1;
    while (busy)
    begin
      base = cyc + 1;
      busy = exp_fire[base + fslot] != expand_pkg::OP_NONE;
      for (int k = 0; k < nrd; k++)
        busy = busy || exp_ren[base + k];
      if (wslot >= 0)
        busy = busy || exp_wen[base + wslot];
      if (busy)
      begin
        @(posedge clk);
        #10;
      end
    end

    for (int k = 0; k < nrd; k++)
    begin
      exp_ren[base + k] = 1'b1;
      exp_rlast[base + k] = seq_last;
      exp_rcnt[base + k] = seq_cnt;
      exp_raddr[base + k] = ra[k];
      exp_roplen[base + k] = ro[k];
      exp_rblen[base + k] = rb[k];
    end
    exp_fire[base + fslot] = unit;
    exp_viu_fn[base + fslot] = fn;
    exp_imm[base + fslot] = imm_exp;
    exp_vau0_fn[base + fslot] = seq_fn_vau0;
    exp_vau1_fn[base + fslot] = seq_fn_vau1;
    if (wslot >= 0)
    begin
      exp_wen[base + wslot] = 1'b1;
      exp_wlast[base + wslot] = seq_last;
      exp_wcnt[base + wslot] = seq_cnt;
      exp_waddr[base + wslot] = seq_vd;
      exp_wsel[base + wslot] = sel;
    end

    seq_viu = unit == expand_pkg::OP_VIU;
    seq_vau0 = unit == expand_pkg::OP_VAU0;
    seq_vau1 = unit == expand_pkg::OP_VAU1;
    seq_vldq = unit == expand_pkg::OP_VLDQ;
    seq_vsdq = unit == expand_pkg::OP_VSDQ;
    ops++;
    @(posedge clk);
    #10;
    {seq_viu, seq_vau0, seq_vau1, seq_vldq, seq_vsdq} = '0;
  endtask

  // Lets in-flight entries drain before the test is summed up.
  task automatic finish_test(input string name);
    repeat (WRITE_DEPTH + 2) @(posedge clk);
    #10;
    tests++;
    $display("test %0d %s: %0d mismatches", tests, name, errors - mark);
    mark = errors;
  endtask

  initial
  begin
    wait (cyc >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    for (int i = 0; i < HIST; i++)
      exp_fire[i] = expand_pkg::OP_NONE;
    reset = 1'b1;
    {seq_viu, seq_vau0, seq_vau1, seq_vldq, seq_vsdq} = '0;
    randomize_fields();
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    reset = 1'b0;

    repeat (20) @(posedge clk);
    #10;
    finish_test("idle after reset");

    // Register/register, zero/register, immediate/register and register/immediate.
    for (int i = 0; i < 12; i++)
    begin
      randomize_fields();
      seq_vs_zero = i[0];
      seq_vt_zero = i[1];
      seq_fn_viu.left = (i < 4 || i >= 10) ? expand_pkg::OPND_REG
        : (i < 8) ? expand_pkg::OPND_ZERO : expand_pkg::OPND_IMM;
      seq_fn_viu.right = (i < 10) ? expand_pkg::OPND_REG : expand_pkg::OPND_IMM;
      issue(expand_pkg::OP_VIU);
    end
    finish_test("viu operand forms");

    for (int i = 0; i < 8; i++)
    begin
      randomize_fields();
      issue(expand_pkg::OP_VAU0);
    end
    finish_test("vau0");

    for (int i = 0; i < 8; i++)
    begin
      randomize_fields();
      seq_fn_vau1[expand_pkg::VAU1_FMA_BIT] = i[0];
      issue(expand_pkg::OP_VAU1);
    end
    finish_test("vau1 fused and two-operand");

    for (int i = 0; i < 8; i++)
    begin
      randomize_fields();
      seq_vt_zero = i[1];
      issue(i[0] ? expand_pkg::OP_VSDQ : expand_pkg::OP_VLDQ);
    end
    finish_test("vldq and vsdq");

    for (int i = 0; i < 40; i++)
    begin
      randomize_fields();
      issue(expand_pkg::unit_op_e'(1 + random_below(5)));
    end
    finish_test("dense mixed sequence");

    $display("%0d tests, %0d operations, %0d mismatches", tests, ops, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- verilog.f
rtl/expand_pkg.sv
rtl/expand_decode.sv
rtl/read_schedule.sv
rtl/fire_schedule.sv
rtl/write_schedule.sv
rtl/vector_expand.sv
test/tb_vector_expand.sv

//--- run.sh
#!/bin/sh
# Builds and runs the vector_expand testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_vector_expand -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/vsim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
